// ==== build.f ====
dcache_pkg.sv
dcache_store.sv
uncached_wfifo.sv
dcache_read_ctrl.sv
dcache_write_ctrl.sv
dcache_top.sv
dcache_asserts.sv
tb_mem_model.sv
tb_dcache.sv

// ==== tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int          INDEX_W    = 7;
    localparam int          FIFO_DEPTH = 4;
    localparam int          PERIOD     = 40;
    localparam int          MEM_WORDS  = 16384;  // 64 KB backing store
    localparam int          N_RANDOM   = 400;
    localparam int          N_ACCESSES = N_RANDOM + 50;
    localparam logic [31:0] SEED       = 32'h5381f9a5;
    localparam logic [31:0] UC_BASE    = 32'h0000_c000;  // Region that is never cached

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        word_t             data;      // First beat
        logic [BE_W-1:0]   be;
        logic              full_be;   // Every beat had all byte enables
        logic              uncached;
        logic [4:0]        beats;
    } burst_rec_t;

    logic       clk;
    logic       rst;
    logic       den;
    logic       uncached;
    cpu_req_t   req;
    logic       data_ok;
    word_t      rdata;
    rd_req_t    rd_bus;
    wr_req_t    wr_bus;
    wr_beat_t   beat_bus;
    logic       req_ok;
    logic       rvalid;
    logic       rlast;
    word_t      bus_rdata;
    logic       wreq_ok;
    logic       wready;
    logic       bvalid;

    word_t      shadow [MEM_WORDS];
    burst_rec_t bursts [$];
    burst_rec_t cur_burst;
    rd_req_t    rd_reqs [$];
    integer     seed = SEED;
    int         errors = 0;

    dcache_top #(.INDEX_W(INDEX_W), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (
        .clk(clk), .rst(rst), .den(den), .req(req), .uncached(uncached),
        .req_ok(req_ok), .rvalid(rvalid), .rlast(rlast), .bus_rdata(bus_rdata),
        .wreq_ok(wreq_ok), .wready(wready), .bvalid(bvalid),
        .data_ok(data_ok), .rdata(rdata), .rd(rd_bus), .wr(wr_bus), .beat(beat_bus)
    );

    tb_mem_model #(.MEM_WORDS(MEM_WORDS), .SEED(SEED)) i_mem (
        .clk(clk), .rst(rst), .rd(rd_bus), .req_ok(req_ok), .rvalid(rvalid),
        .rlast(rlast), .rdata(bus_rdata), .wr(wr_bus), .wreq_ok(wreq_ok),
        .wready(wready), .bvalid(bvalid), .beat(beat_bus)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic word_t initial_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h6a09_e667;
    endfunction

    // Memory contents as the CPU must see them
    function automatic word_t expected_word(input logic [31:0] addr);
        return shadow[addr[15:2]];
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int index, input int word_idx);
        return (tag << (INDEX_W + LINE_BYTE_W)) | (index << LINE_BYTE_W) | (word_idx << 2);
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input word_t data,
                                input logic [BE_W-1:0] be);
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) shadow[addr[15:2]][8*b +: 8] = data[8*b +: 8];
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    // Starts and ends on a falling edge, data_ok is sampled on the rising edge
    task automatic cpu_access(input logic [31:0] addr, input word_t data,
                              input logic [BE_W-1:0] be, input logic unc,
                              output word_t got, output int cycles);
        den      = 1'b1;
        req      = '{addr: addr, wdata: data, be: be};
        uncached = unc;
        cycles   = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!data_ok);
        got = rdata;
        @(negedge clk);
        den = 1'b0;
        if (be != '0) shadow_write(addr, data, be);
    endtask

    task automatic read_check(input logic [31:0] addr, input logic unc, output int cycles);
        word_t got;
        cpu_access(addr, '0, '0, unc, got, cycles);
        compare_value($sformatf("rdata[%h]", addr), got, expected_word(addr));
    endtask

    task automatic write_word(input logic [31:0] addr, input word_t data,
                              input logic [BE_W-1:0] be, input logic unc, output int cycles);
        word_t got;
        cpu_access(addr, data, be, unc, got, cycles);
    endtask

    // Read request monitor
    always @(posedge clk) begin
        if (!rst && rd_bus.strobe && req_ok) rd_reqs.push_back(rd_bus);
    end

    // Write port monitor
    always @(posedge clk) begin
        if (!rst && wr_bus.strobe && wreq_ok) begin
            cur_burst          = '0;
            cur_burst.addr     = wr_bus.addr;
            cur_burst.uncached = wr_bus.uncached;
            cur_burst.full_be  = 1'b1;
        end
        if (!rst && beat_bus.valid && wready) begin
            if (cur_burst.beats == 0) begin
                cur_burst.data = beat_bus.data;
                cur_burst.be   = beat_bus.be;
            end
            cur_burst.full_be = cur_burst.full_be && (beat_bus.be == '1);
            cur_burst.beats   = cur_burst.beats + 1'b1;
            if (beat_bus.last) bursts.push_back(cur_burst);
        end
    end

    initial begin
        repeat (N_ACCESSES * 200) @(posedge clk);
        $display("Timeout: accesses still running after %0d cycles", N_ACCESSES * 200);
        $display("Test failed");
        $finish;
    end

    initial begin
        word_t       uc_data [3];
        logic [3:0]  uc_be [3];
        logic [31:0] addr;
        logic [31:0] r;
        logic        unc;
        burst_rec_t  rec;
        rd_req_t     rrec;
        int          cycles;
        int          idx_set [3];

        rst      = 1'b1;
        den      = 1'b0;
        req      = '0;
        uncached = 1'b0;
        idx_set  = '{5, 9, 40};
        for (int i = 0; i < MEM_WORDS; i++) shadow[i] = initial_word(i << 2);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Line fill, then every word of the line hits
        rd_reqs.delete();
        read_check(make_addr(1, 5, 7), 1'b0, cycles);
        compare_value("read request count", rd_reqs.size(), 1);
        if (rd_reqs.size() > 0) begin
            rrec = rd_reqs.pop_front();
            compare_value("rd.addr", rrec.addr, make_addr(1, 5, 0));
            compare_value("rd.uncached", rrec.uncached, 0);
        end
        rd_reqs.delete();
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            read_check(make_addr(1, 5, w), 1'b0, cycles);
            compare_value("data_ok latency", cycles, 1);
        end
        compare_value("read request count", rd_reqs.size(), 0);

        write_word(make_addr(1, 5, 3), 32'hdead_beef, 4'b0110, 1'b0, cycles);
        compare_value("data_ok latency", cycles, 1);
        read_check(make_addr(1, 5, 3), 1'b0, cycles);
        write_word(make_addr(0, 9, 2), 32'h1234_5678, 4'b1001, 1'b0, cycles);  // Write miss
        read_check(make_addr(0, 9, 2), 1'b0, cycles);

        // Dirty victim at index 9 goes out as one line burst
        bursts.delete();
        read_check(make_addr(2, 9, 4), 1'b0, cycles);
        compare_value("write burst count", bursts.size(), 1);
        if (bursts.size() > 0) begin
            rec = bursts.pop_front();
            compare_value("wr.addr", rec.addr, make_addr(0, 9, 0));
            compare_value("beat count", rec.beats, 16);
            compare_value("beat.be all set", rec.full_be, 1);
            compare_value("wr.uncached", rec.uncached, 0);
            compare_value("beat.data", rec.data, expected_word(make_addr(0, 9, 0)));
        end
        bursts.delete();
        read_check(make_addr(0, 9, 2), 1'b0, cycles);
        compare_value("write burst count", bursts.size(), 0);

        bursts.delete();
        for (int k = 0; k < 3; k++) begin
            uc_data[k] = $random(seed);
            uc_be[k]   = 4'(1 + {$random(seed)} % 15);
            write_word(UC_BASE + 4 * k, uc_data[k], uc_be[k], 1'b1, cycles);
            compare_value("data_ok latency", cycles, 1);
        end
        rd_reqs.delete();
        for (int k = 0; k < 3; k++) read_check(UC_BASE + 4 * k, 1'b1, cycles);
        compare_value("read request count", rd_reqs.size(), 3);
        for (int k = 0; k < 3 && rd_reqs.size() > 0; k++) begin
            rrec = rd_reqs.pop_front();
            compare_value("rd.addr", rrec.addr, UC_BASE + 4 * k);
            compare_value("rd.uncached", rrec.uncached, 1);
        end
        compare_value("write burst count", bursts.size(), 3);
        for (int k = 0; k < 3 && bursts.size() > 0; k++) begin
            rec = bursts.pop_front();
            compare_value("wr.addr", rec.addr, UC_BASE + 4 * k);
            compare_value("wr.uncached", rec.uncached, 1);
            compare_value("beat count", rec.beats, 1);
            compare_value("beat.be", rec.be, uc_be[k]);
            compare_value("beat.data", rec.data, uc_data[k]);
        end
        // Enough back to back to fill the FIFO
        for (int k = 0; k < 8; k++) begin
            write_word(UC_BASE + 32'h40 + 4 * k, $random(seed), 4'hf, 1'b1, cycles);
        end
        for (int k = 0; k < 8; k++) read_check(UC_BASE + 32'h40 + 4 * k, 1'b1, cycles);

        for (int n = 0; n < N_RANDOM; n++) begin
            r   = $random(seed);
            unc = (r[7:5] == 3'd0);
            if (unc) addr = UC_BASE + ({$random(seed)} % 64) * 4;
            else addr = make_addr({$random(seed)} % 3, idx_set[{$random(seed)} % 3], r[11:8]);
            if (r[4]) write_word(addr, $random(seed), (r[3:0] == 0) ? 4'hf : r[3:0], unc, cycles);
            else read_check(addr, unc, cycles);
        end

        $display("Errors: %0d from checks, %0d from assertions",
                 errors, i_dut.i_asserts.fail_count);
        if (errors == 0 && i_dut.i_asserts.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int          MEM_WORDS = 16384,
    parameter logic [31:0] SEED      = 32'h5381f9a5
) (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::rd_req_t  rd,
    output logic                 req_ok,
    output logic                 rvalid,
    output logic                 rlast,
    output dcache_pkg::word_t    rdata,
    input  dcache_pkg::wr_req_t  wr,
    output logic                 wreq_ok,
    output logic                 wready,
    output logic                 bvalid,
    input  dcache_pkg::wr_beat_t beat
);
    import dcache_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    word_t       mem [MEM_WORDS];
    integer      rd_seed = SEED;
    integer      wr_seed = SEED;
    logic [1:0]  rd_phase;  // Idle, accept delay, beats
    logic [1:0]  wr_phase;  // Idle, accept delay, beats, response
    int          rd_wait;
    int          wr_wait;
    int          rd_left;
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;

    initial begin
        req_ok  = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        wreq_ok = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (i << 2) ^ {16'(i << 2), 16'h0} ^ 32'h6a09_e667;
        end
    end

    always @(posedge clk) begin
        req_ok <= 1'b0;
        rvalid <= 1'b0;
        rlast  <= 1'b0;
        if (rst) begin
            rd_phase <= 2'd0;
        end else begin
            case (rd_phase)
                2'd0: if (rd.strobe) begin
                    rd_wait  <= $random(rd_seed) & 3;
                    rd_phase <= 2'd1;
                end
                2'd1: if (rd_wait != 0) begin
                    rd_wait <= rd_wait - 1;
                end else if (req_ok) begin
                    rd_addr  <= rd.addr;
                    rd_left  <= rd.uncached ? 1 : WORDS_PER_LINE;
                    rd_phase <= 2'd2;
                end else begin
                    req_ok <= 1'b1;
                end
                default: if (($random(rd_seed) & 3) != 0) begin  // Gap one beat in four
                    rvalid  <= 1'b1;
                    rlast   <= (rd_left == 1);
                    rdata   <= mem[rd_addr[AW+1:2]];
                    rd_addr <= rd_addr + 4;
                    rd_left <= rd_left - 1;
                    if (rd_left == 1) rd_phase <= 2'd0;
                end
            endcase
        end
    end

    always @(posedge clk) begin
        wreq_ok <= 1'b0;
        wready  <= 1'b0;
        bvalid  <= 1'b0;
        if (rst) begin
            wr_phase <= 2'd0;
        end else begin
            case (wr_phase)
                2'd0: if (wr.strobe) begin
                    wr_wait  <= $random(wr_seed) & 3;
                    wr_phase <= 2'd1;
                end
                2'd1: if (wr_wait != 0) begin
                    wr_wait <= wr_wait - 1;
                end else if (wreq_ok) begin
                    wr_addr  <= wr.addr;
                    wr_phase <= 2'd2;
                end else begin
                    wreq_ok <= 1'b1;
                end
                2'd2: begin
                    if (wready && beat.valid) begin
                        for (int b = 0; b < BE_W; b++) begin
                            if (beat.be[b]) mem[wr_addr[AW+1:2]][8*b +: 8] <= beat.data[8*b +: 8];
                        end
                        wr_addr <= wr_addr + 4;
                    end
                    if (wready && beat.valid && beat.last) begin
                        wr_wait  <= $random(wr_seed) & 3;
                        wr_phase <= 2'd3;
                    end else begin
                        wready <= ($random(wr_seed) & 1) != 0;
                    end
                end
                default: if (wr_wait != 0) begin
                    wr_wait <= wr_wait - 1;
                end else begin
                    bvalid   <= 1'b1;
                    wr_phase <= 2'd0;
                end
            endcase
        end
    end

endmodule

// ==== dcache_asserts.sv ====
`timescale 1ns/1ps

module dcache_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 data_ok,
    input dcache_pkg::rd_req_t  rd,
    input logic                 req_ok,
    input dcache_pkg::wr_req_t  wr,
    input logic                 wreq_ok,
    input dcache_pkg::wr_beat_t beat
);

    int unsigned fail_count = 0;

    rd_held: assert property (@(posedge clk) disable iff (rst)
        rd.strobe && !req_ok |=> rd.strobe && $stable(rd.addr))
        else begin
            fail_count++;
            $error("read strobe dropped or address moved before req_ok");
        end

    wr_held: assert property (@(posedge clk) disable iff (rst)
        wr.strobe && !wreq_ok |=> wr.strobe && $stable(wr.addr))
        else begin
            fail_count++;
            $error("write strobe dropped or address moved before wreq_ok");
        end

    last_with_valid: assert property (@(posedge clk) disable iff (rst)
        beat.last |-> beat.valid)
        else begin
            fail_count++;
            $error("beat last raised without beat valid");
        end

    // No completion while the cache is being reset
    quiet_in_reset: assert property (@(posedge clk) rst |-> !data_ok)
        else begin
            fail_count++;
            $error("data_ok high during reset");
        end

endmodule

bind dcache_top dcache_asserts i_asserts (
    .clk(clk), .rst(rst), .data_ok(data_ok), .rd(rd), .req_ok(req_ok),
    .wr(wr), .wreq_ok(wreq_ok), .beat(beat)
);

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
    parameter int INDEX_W    = 7,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 den,
    input  dcache_pkg::cpu_req_t req,
    input  logic                 uncached,
    input  logic                 req_ok,
    input  logic                 rvalid,
    input  logic                 rlast,
    input  dcache_pkg::word_t    bus_rdata,
    input  logic                 wreq_ok,
    input  logic                 wready,
    input  logic                 bvalid,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    output dcache_pkg::rd_req_t  rd,
    output dcache_pkg::wr_req_t  wr,
    output dcache_pkg::wr_beat_t beat
);
    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - LINE_BYTE_W;

    logic [INDEX_W-1:0] st_index;
    logic               st_we;
    logic [TAG_W-1:0]   st_wtag;
    line_data_t         st_wline;
    logic               st_wdirty;
    logic [TAG_W-1:0]   st_tag;
    line_data_t         st_line;
    logic               st_valid;
    logic               st_dirty;

    logic               fifo_push;
    logic               fifo_pop;
    logic               fifo_full;
    logic               fifo_empty;
    uc_write_t          fifo_din;
    uc_write_t          fifo_dout;

    logic               wb_start;
    logic [ADDR_W-1:0]  wb_addr;
    logic               wr_idle;

    dcache_store #(.INDEX_W(INDEX_W)) i_store (
        .clk(clk), .rst(rst), .index(st_index), .we(st_we), .wtag(st_wtag),
        .wline(st_wline), .wdirty(st_wdirty), .rtag(st_tag), .rline(st_line),
        .rvalid_bit(st_valid), .rdirty_bit(st_dirty)
    );

    uncached_wfifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(uc_write_t)) i_wfifo (
        .clk(clk), .rst(rst), .push(fifo_push), .din(fifo_din), .pop(fifo_pop),
        .dout(fifo_dout), .full(fifo_full), .empty(fifo_empty)
    );

    dcache_read_ctrl #(.INDEX_W(INDEX_W)) i_read_ctrl (
        .clk(clk), .rst(rst), .den(den), .req(req), .uncached(uncached),
        .data_ok(data_ok), .rdata(rdata), .rd(rd), .req_ok(req_ok),
        .rvalid(rvalid), .rlast(rlast), .bus_rdata(bus_rdata),
        .st_index(st_index), .st_we(st_we), .st_wtag(st_wtag), .st_wline(st_wline),
        .st_wdirty(st_wdirty), .st_tag(st_tag), .st_line(st_line),
        .st_valid(st_valid), .st_dirty(st_dirty),
        .fifo_push(fifo_push), .fifo_din(fifo_din), .fifo_full(fifo_full),
        .fifo_empty(fifo_empty), .wb_start(wb_start), .wb_addr(wb_addr), .wr_idle(wr_idle)
    );

    // Victim data comes straight off the store read port
    dcache_write_ctrl #(.INDEX_W(INDEX_W)) i_write_ctrl (
        .clk(clk), .rst(rst), .wb_start(wb_start), .wb_addr(wb_addr),
        .victim(st_line), .fifo_dout(fifo_dout), .fifo_empty(fifo_empty),
        .wreq_ok(wreq_ok), .wready(wready), .bvalid(bvalid),
        .wr(wr), .beat(beat), .fifo_pop(fifo_pop), .wr_idle(wr_idle)
    );

endmodule

// ==== dcache_write_ctrl.sv ====
`timescale 1ns/1ps

module dcache_write_ctrl #(
    parameter int INDEX_W = 7,
    localparam int TAG_W  = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::LINE_BYTE_W
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wb_start,
    input  logic [dcache_pkg::ADDR_W-1:0] wb_addr,
    input  dcache_pkg::line_data_t        victim,
    input  dcache_pkg::uc_write_t         fifo_dout,
    input  logic                          fifo_empty,
    input  logic                          wreq_ok,
    input  logic                          wready,
    input  logic                          bvalid,
    output dcache_pkg::wr_req_t           wr,
    output dcache_pkg::wr_beat_t          beat,
    output logic                          fifo_pop,
    output logic                          wr_idle
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        W_IDLE, W_UC_REQ, W_UC_BEAT, W_WB_REQ, W_WB_BEAT, W_RESP
    } wstate_t;

    wstate_t             state;
    wstate_t             next_state;
    logic                wb_pend;
    logic                wb_take;
    logic [TAG_W-1:0]    wb_tag;
    logic [INDEX_W-1:0]  wb_index;
    logic [OFFSET_W-1:0] beat_cnt;

    assign wr_idle = (state == W_IDLE) && !wb_pend;

    always_ff @(posedge clk) begin
        if (rst) state <= W_IDLE;
        else state <= next_state;
    end

    // Write-back request survives a FIFO drain
    always_ff @(posedge clk) begin
        if (rst) wb_pend <= 1'b0;
        else if (wb_start) wb_pend <= 1'b1;
        else if (wb_take) wb_pend <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (wb_start) begin
            wb_tag   <= wb_addr[ADDR_W-1 -: TAG_W];
            wb_index <= wb_addr[LINE_BYTE_W +: INDEX_W];
        end
        if (state == W_WB_REQ) beat_cnt <= '0;
        else if (state == W_WB_BEAT && wready) beat_cnt <= beat_cnt + 1'b1;
    end

    always_comb begin
        next_state = state;
        wr         = '0;
        beat       = '0;
        fifo_pop   = 1'b0;
        wb_take    = 1'b0;
        case (state)
            W_IDLE: begin
                if (!fifo_empty) begin
                    next_state = W_UC_REQ;  // Posted writes go first
                end else if (wb_pend) begin
                    wb_take    = 1'b1;
                    next_state = W_WB_REQ;
                end
            end
            W_UC_REQ: begin
                wr.addr     = fifo_dout.addr;
                wr.strobe   = 1'b1;
                wr.uncached = 1'b1;
                if (wreq_ok) next_state = W_UC_BEAT;
            end
            W_UC_BEAT: begin
                beat.data  = fifo_dout.data;
                beat.be    = fifo_dout.be;
                beat.valid = 1'b1;
                beat.last  = 1'b1;
                fifo_pop   = wready;
                if (wready) next_state = W_RESP;
            end
            W_WB_REQ: begin
                wr.addr   = {wb_tag, wb_index, {LINE_BYTE_W{1'b0}}};
                wr.strobe = 1'b1;
                if (wreq_ok) next_state = W_WB_BEAT;
            end
            W_WB_BEAT: begin
                beat.data  = victim[beat_cnt];  // Store still indexed at the victim set
                beat.be    = '1;
                beat.valid = 1'b1;
                beat.last  = &beat_cnt;
                if (wready && &beat_cnt) next_state = W_RESP;
            end
            W_RESP: begin
                if (bvalid) next_state = W_IDLE;
            end
            default: next_state = W_IDLE;
        endcase
    end

endmodule

// ==== dcache_read_ctrl.sv ====
`timescale 1ns/1ps

module dcache_read_ctrl #(
    parameter int INDEX_W = 7,
    localparam int TAG_W  = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::LINE_BYTE_W
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          den,
    input  dcache_pkg::cpu_req_t          req,
    input  logic                          uncached,
    output logic                          data_ok,
    output dcache_pkg::word_t             rdata,
    output dcache_pkg::rd_req_t           rd,
    input  logic                          req_ok,
    input  logic                          rvalid,
    input  logic                          rlast,
    input  dcache_pkg::word_t             bus_rdata,
    output logic [INDEX_W-1:0]            st_index,
    output logic                          st_we,
    output logic [TAG_W-1:0]              st_wtag,
    output dcache_pkg::line_data_t        st_wline,
    output logic                          st_wdirty,
    input  logic [TAG_W-1:0]              st_tag,
    input  dcache_pkg::line_data_t        st_line,
    input  logic                          st_valid,
    input  logic                          st_dirty,
    output logic                          fifo_push,
    output dcache_pkg::uc_write_t         fifo_din,
    input  logic                          fifo_full,
    input  logic                          fifo_empty,
    output logic                          wb_start,
    output logic [dcache_pkg::ADDR_W-1:0] wb_addr,
    input  logic                          wr_idle
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_RD_REQ, S_RD_DATA, S_WB_WAIT, S_REFILL, S_UC_REQ, S_UC_DATA
    } state_t;

    state_t              state;
    state_t              next_state;
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
    logic                is_write;
    logic                hit;
    logic                drained;
    logic [OFFSET_W-1:0] rx_cnt;
    line_data_t          rx_buf;

    function automatic word_t merge(word_t old_w, word_t new_w, logic [BE_W-1:0] be);
        word_t res;
        res = old_w;
        for (int i = 0; i < BE_W; i++) begin
            if (be[i]) res[8*i +: 8] = new_w[8*i +: 8];
        end
        return res;
    endfunction

    assign tag      = req.addr[ADDR_W-1 -: TAG_W];
    assign index    = req.addr[LINE_BYTE_W +: INDEX_W];
    assign offset   = req.addr[LINE_BYTE_W-1 -: OFFSET_W];
    assign is_write = |req.be;
    assign hit      = st_valid && (st_tag == tag);
    assign drained  = fifo_empty && wr_idle;  // No posted write still in flight

    assign st_index = index;
    assign wb_addr  = {st_tag, index, {LINE_BYTE_W{1'b0}}};
    assign fifo_din = '{addr: req.addr, data: req.wdata, be: req.be};

    always_ff @(posedge clk) begin
        if (rst) state <= S_IDLE;
        else state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (state == S_RD_REQ) begin
            rx_cnt <= '0;
        end else if (state == S_RD_DATA && rvalid) begin
            rx_buf[rx_cnt] <= bus_rdata;
            rx_cnt         <= rx_cnt + 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        data_ok    = 1'b0;
        rdata      = st_line[offset];
        rd         = '0;
        st_we      = 1'b0;
        st_wtag    = tag;
        st_wline   = st_line;
        st_wdirty  = 1'b0;
        fifo_push  = 1'b0;
        wb_start   = 1'b0;
        case (state)
            S_IDLE: begin
                if (den && uncached && is_write) begin
                    fifo_push = !fifo_full;  // Posted, CPU holds while full
                    data_ok   = !fifo_full;
                end else if (den && uncached) begin
                    if (drained) next_state = S_UC_REQ;
                end else if (den && hit) begin
                    data_ok = 1'b1;
                    if (is_write) begin
                        st_we            = 1'b1;
                        st_wdirty        = 1'b1;
                        st_wline[offset] = merge(st_line[offset], req.wdata, req.be);
                    end
                end else if (den && drained) begin
                    wb_start   = st_valid && st_dirty;  // Victim goes out alongside refill
                    next_state = S_RD_REQ;
                end
            end
            S_RD_REQ: begin
                rd.addr   = {req.addr[ADDR_W-1:LINE_BYTE_W], {LINE_BYTE_W{1'b0}}};
                rd.strobe = 1'b1;
                if (req_ok) next_state = S_RD_DATA;
            end
            S_RD_DATA: begin
                if (rvalid && rlast) next_state = wr_idle ? S_REFILL : S_WB_WAIT;
            end
            S_WB_WAIT: begin
                if (wr_idle) next_state = S_REFILL;  // Victim must leave before overwrite
            end
            S_REFILL: begin
                st_we      = 1'b1;
                st_wline   = rx_buf;
                data_ok    = !is_write;  // Writes retry as a hit
                rdata      = rx_buf[offset];
                next_state = S_IDLE;
            end
            S_UC_REQ: begin
                rd.addr     = req.addr;
                rd.strobe   = 1'b1;
                rd.uncached = 1'b1;
                if (req_ok) next_state = S_UC_DATA;
            end
            S_UC_DATA: begin
                data_ok = rvalid;
                rdata   = bus_rdata;
                if (rvalid && rlast) next_state = S_IDLE;
            end
            default: next_state = S_IDLE;
        endcase
    end

endmodule

// ==== uncached_wfifo.sv ====
`timescale 1ns/1ps

module uncached_wfifo #(
    parameter int  FIFO_DEPTH = 4,
    parameter type payload_t  = logic [67:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;  // Push while full is dropped
    assign do_pop  = pop && !empty;
    assign dout    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

endmodule

// ==== dcache_store.sv ====
`timescale 1ns/1ps

module dcache_store #(
    parameter int INDEX_W = 7,
    localparam int TAG_W  = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::LINE_BYTE_W
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [INDEX_W-1:0]     index,
    input  logic                   we,
    input  logic [TAG_W-1:0]       wtag,
    input  dcache_pkg::line_data_t wline,
    input  logic                   wdirty,
    output logic [TAG_W-1:0]       rtag,
    output dcache_pkg::line_data_t rline,
    output logic                   rvalid_bit,
    output logic                   rdirty_bit
);
    import dcache_pkg::*;

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0] tag_mem [SETS];
    line_data_t       line_mem [SETS];
    logic [SETS-1:0]  valid_bits;
    logic [SETS-1:0]  dirty_bits;

    // Single address, read is combinational
    assign rtag       = tag_mem[index];
    assign rline      = line_mem[index];
    assign rvalid_bit = valid_bits[index];
    assign rdirty_bit = dirty_bits[index];

    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[index]  <= wtag;
            line_mem[index] <= wline;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (we) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= wdirty;  // Refill clean, hit write dirty
        end
    end

endmodule

// ==== dcache_pkg.sv ====
package dcache_pkg;

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int BE_W           = DATA_W / 8;
    localparam int WORDS_PER_LINE = 16;
    localparam int OFFSET_W       = 4;  // Word within a line
    localparam int LINE_BYTE_W    = 6;  // Byte within a line

    typedef logic [DATA_W-1:0] word_t;

    // Word 0 sits in the low bits
    typedef word_t [WORDS_PER_LINE-1:0] line_data_t;

    // A write is any access with a nonzero byte enable
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
        logic [BE_W-1:0]   be;
    } cpu_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        word_t             data;
        logic [BE_W-1:0]   be;
    } uc_write_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              strobe;    // Held until req_ok
        logic              uncached;  // Single beat instead of a line
    } rd_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              strobe;    // Held until wreq_ok
        logic              uncached;
    } wr_req_t;

    typedef struct packed {
        word_t           data;
        logic [BE_W-1:0] be;
        logic            valid;
        logic            last;
    } wr_beat_t;

endpackage
